// File: video_pkg.sv
package video_pkg;

  // 1080p raster, one mode only
  localparam int H_TOTAL = 2200;  // clocks per line
  localparam int H_FP    = 88;    // front porch
  localparam int H_BP    = 148;   // back porch
  localparam int H_SYNC  = 44;    // hsync width
  localparam int H_ACT   = 1920;  // visible pixels
  localparam int V_TOTAL = 1125;  // lines per frame
  localparam int V_FP    = 4;
  localparam int V_BP    = 36;
  localparam int V_SYNC  = 5;
  localparam int V_ACT   = 1080;

  // active window edges, counted from the sync start
  localparam int H_ACT_START = H_SYNC + H_BP;
  localparam int H_ACT_END   = H_TOTAL - H_FP;  // first blank column after video
  localparam int V_ACT_START = V_SYNC + V_BP;
  localparam int V_ACT_END   = V_TOTAL - V_FP;

  localparam int RST_DELAY_CYCLES = 10000;  // lock to release
  localparam int RST_CNT_W        = $clog2(RST_DELAY_CYCLES + 1);

  localparam int I2C_QUARTER = 25;  // cfg_clk cycles per scl quarter
  localparam int I2C_QW      = $clog2(I2C_QUARTER);

  localparam logic [6:0] TX_DEV_ADDR = 7'h2B;  // transmitter slave address
  localparam int         CFG_LEN     = 8;
  localparam int         CFG_IDX_W   = $clog2(CFG_LEN);

  // {reg addr, data} per entry, sent in order
  localparam logic [15:0] CFG_TABLE [0:CFG_LEN-1] = '{
    16'h0801,  // soft reset release
    16'h0A10,  // input bus format
    16'h1A00,  // tmds off while programming
    16'h1E00,  // power state d0
    16'h2600,  // audio mute
    16'h3F01,  // avi infoframe enable
    16'hC701,  // hdmi mode
    16'h1A01   // tmds on
  };

  typedef logic [11:0]          coord_t;        // pixel / line coordinate
  typedef logic [RST_CNT_W-1:0] rst_cnt_t;      // reset delay count
  typedef logic [I2C_QW-1:0]    quarter_cnt_t;  // scl quarter divider
  typedef logic [CFG_IDX_W-1:0] cfg_idx_t;      // table entry index

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  typedef struct packed {
    logic vs;
    logic hs;
    logic de;
  } sync_t;

  typedef enum logic [1:0] {
    CFG_IDLE,   // waiting for run
    CFG_ISSUE,  // hand one byte to the i2c master
    CFG_WAIT,   // byte on the bus
    CFG_DONE
  } cfg_state_t;

  typedef enum logic [2:0] {
    I2C_IDLE,   // bus free, scl high
    I2C_START,
    I2C_BITS,
    I2C_ACK,
    I2C_HOLD,   // mid transaction, scl parked low
    I2C_STOP
  } i2c_state_t;

endpackage

// File: reset_delay.sv
`timescale 1ns/1ns

module reset_delay import video_pkg::*; (
  input  logic cfg_clk,
  input  logic rst,
  input  logic locked,
  output logic run
);

  rst_cnt_t cnt;  // cycles since lock

  always_ff @(posedge cfg_clk) begin
    if (rst || !locked) begin
      cnt <= '0;  // lost lock restarts the wait
    end else if (!run) begin
      cnt <= cnt + rst_cnt_t'(1);  // saturates once run is set
    end
  end

  // release after exactly RST_DELAY_CYCLES locked cycles
  assign run = (cnt == rst_cnt_t'(RST_DELAY_CYCLES));

  // once released, only a lock drop or rst takes the path back down
  a_run_stays : assert property (@(posedge cfg_clk)
    (run && locked && !rst) |=> run)
    else $error("run fell while locked held high");

endmodule

// File: video_timing.sv
`timescale 1ns/1ns

module video_timing import video_pkg::*; (
  input  logic   cfg_clk,
  input  logic   rst,
  input  logic   run,
  output sync_t  sync,
  output coord_t act_x,
  output coord_t act_y
);

  coord_t h_cnt;  // column, 0 at hsync start
  coord_t v_cnt;  // line, 0 at vsync start
  logic   h_last;
  logic   v_last;
  logic   h_act;
  logic   v_act;

  assign h_last = (h_cnt == coord_t'(H_TOTAL - 1));
  assign v_last = (v_cnt == coord_t'(V_TOTAL - 1));

  // active windows sit between back porch and front porch
  assign h_act = (h_cnt >= coord_t'(H_ACT_START)) && (h_cnt < coord_t'(H_ACT_END));
  assign v_act = (v_cnt >= coord_t'(V_ACT_START)) && (v_cnt < coord_t'(V_ACT_END));

  // raster counters, parked at the origin until run
  always_ff @(posedge cfg_clk) begin
    if (rst || !run) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;  // line wrap
      if (v_last) begin
        v_cnt <= '0;  // frame wrap
      end else begin
        v_cnt <= v_cnt + coord_t'(1);
      end
    end else begin
      h_cnt <= h_cnt + coord_t'(1);
    end
  end

  // registered decode, first valid output is for count (0,0)
  always_ff @(posedge cfg_clk) begin
    if (rst || !run) begin
      sync  <= '0;
      act_x <= '0;
      act_y <= '0;
    end else begin
      sync.hs <= (h_cnt < coord_t'(H_SYNC));  // active high
      sync.vs <= (v_cnt < coord_t'(V_SYNC));
      sync.de <= h_act && v_act;
      if (h_act && v_act) begin
        act_x <= h_cnt - coord_t'(H_ACT_START);  // 0 at first visible pixel
        act_y <= v_cnt - coord_t'(V_ACT_START);
      end else begin
        act_x <= '0;  // coords idle at zero in blanking
        act_y <= '0;
      end
    end
  end

  // coordinates presented to the pixel source stay inside the frame
  a_coord_range : assert property (@(posedge cfg_clk) disable iff (rst)
    sync.de |-> (act_x < coord_t'(H_ACT)) && (act_y < coord_t'(V_ACT)))
    else $error("active coordinate outside frame");

endmodule

// File: pixel_stage.sv
`timescale 1ns/1ns

module pixel_stage import video_pkg::*; (
  input  logic  cfg_clk,
  input  logic  rst,
  input  logic  run,
  input  sync_t sync_in,
  input  rgb_t  pixel_data,
  output sync_t sync_out,
  output rgb_t  pix_out
);

  // one register stage so sync and pixel leave together
  always_ff @(posedge cfg_clk) begin
    if (rst || !run) begin
      sync_out <= '0;
      pix_out  <= '0;  // black while held
    end else begin
      sync_out <= sync_in;
      if (sync_in.de) begin
        pix_out <= pixel_data;  // source answered act_x/act_y this cycle
      end else begin
        pix_out <= '0;  // blank outside the active window
      end
    end
  end

  // no colour leaks into blanking
  a_blank_zero : assert property (@(posedge cfg_clk) disable iff (rst)
    !sync_out.de |-> (pix_out == '0))
    else $error("pix_out nonzero during blanking");

endmodule

// File: i2c_master.sv
`timescale 1ns/1ns

module i2c_master import video_pkg::*; (
  input  logic       cfg_clk,
  input  logic       rst,
  input  logic       start,
  input  logic       first,
  input  logic       last,
  input  logic [7:0] tx_byte,
  output logic       busy,
  output logic       nack,
  output logic       scl,
  output logic       sda_out_en,
  input  logic       sda_in
);

  i2c_state_t   state;
  quarter_cnt_t q_cnt;      // cycles inside a quarter
  logic [1:0]   phase;      // quarter inside a bit
  logic [2:0]   bit_cnt;    // data bit index counting msb first
  logic         stop_pend;  // close the bus after this byte
  logic [7:0]   shreg;      // byte being shifted out
  logic         tick;       // last cycle of a quarter

  assign tick = (q_cnt == quarter_cnt_t'(I2C_QUARTER - 1));
  assign busy = (state != I2C_IDLE) && (state != I2C_HOLD);

  // bus levels per state and quarter with scl high in quarters 1 and 2 of a bit
  always_comb begin
    unique case (state)
      I2C_IDLE: begin
        scl        = 1'b1;
        sda_out_en = 1'b0;
      end
      I2C_START: begin
        scl        = (phase != 2'd3);
        sda_out_en = (phase >= 2'd2);  // sda falls with scl high
      end
      I2C_BITS: begin
        scl        = (phase == 2'd1) || (phase == 2'd2);
        sda_out_en = !shreg[7];  // pull low for a 0 bit
      end
      I2C_ACK: begin
        scl        = (phase == 2'd1) || (phase == 2'd2);
        sda_out_en = 1'b0;  // slave owns sda
      end
      I2C_HOLD: begin
        scl        = 1'b0;
        sda_out_en = 1'b0;
      end
      default: begin  // stop
        scl        = (phase != 2'd0);
        sda_out_en = (phase <= 2'd1);  // sda rises with scl high
      end
    endcase
  end

  always_ff @(posedge cfg_clk) begin
    if (rst) begin
      state     <= I2C_IDLE;
      q_cnt     <= '0;
      phase     <= '0;
      bit_cnt   <= '0;
      stop_pend <= 1'b0;
      nack      <= 1'b0;
    end else if (!busy) begin
      if (start) begin
        state     <= first ? I2C_START : I2C_BITS;
        q_cnt     <= '0;
        phase     <= '0;
        bit_cnt   <= '0;
        stop_pend <= last;
        nack      <= 1'b0;  // fresh status per byte
      end
    end else if (!tick) begin
      q_cnt <= q_cnt + quarter_cnt_t'(1);
    end else begin
      q_cnt <= '0;
      phase <= phase + 2'd1;
      if (state == I2C_ACK && phase == 2'd1) begin
        nack <= sda_in;  // sampled while scl high
      end
      if (phase == 2'd3) begin
        unique case (state)
          I2C_START: state <= I2C_BITS;
          I2C_BITS: begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= I2C_ACK;
            end
          end
          I2C_ACK: state <= (stop_pend || nack) ? I2C_STOP : I2C_HOLD;  // nack aborts
          default: state <= I2C_IDLE;  // stop done
        endcase
      end
    end
  end

  // data shifter
  always_ff @(posedge cfg_clk) begin
    if (!busy && start) begin
      shreg <= tx_byte;
    end else if (state == I2C_BITS && tick && phase == 2'd3) begin
      shreg <= {shreg[6:0], 1'b0};  // next bit lands while scl low
    end
  end

  // sda only moves under scl high for start and stop
  a_sda_stable : assert property (@(posedge cfg_clk) disable iff (rst)
    (scl && $past(scl) && !(state inside {I2C_START, I2C_STOP})
      && !($past(state) inside {I2C_START, I2C_STOP})) |-> $stable(sda_out_en))
    else $error("sda changed while scl high");

endmodule

// File: tx_config.sv
`timescale 1ns/1ns

module tx_config import video_pkg::*; (
  input  logic       cfg_clk,
  input  logic       rst,
  input  logic       run,
  output logic       start,
  output logic       first,
  output logic       last,
  output logic [7:0] tx_byte,
  input  logic       busy,
  input  logic       nack,
  output logic       init_over
);

  cfg_state_t state;
  cfg_idx_t   entry;     // table row in flight
  logic [1:0] byte_idx;  // 0 dev addr, 1 reg, 2 data

  assign start = (state == CFG_ISSUE) && !busy;
  assign first = (byte_idx == 2'd0);  // start condition before dev addr
  assign last  = (byte_idx == 2'd2);  // stop after data byte

  always_comb begin
    unique case (byte_idx)
      2'd0:    tx_byte = {TX_DEV_ADDR, 1'b0};  // write
      2'd1:    tx_byte = CFG_TABLE[entry][15:8];
      default: tx_byte = CFG_TABLE[entry][7:0];
    endcase
  end

  always_ff @(posedge cfg_clk) begin
    if (rst) begin
      state     <= CFG_IDLE;
      entry     <= '0;
      byte_idx  <= '0;
      init_over <= 1'b0;
    end else begin
      unique case (state)
        CFG_IDLE: begin
          if (run) begin
            state <= CFG_ISSUE;  // video path out of reset
          end
        end
        CFG_ISSUE: begin
          if (!busy) begin
            state <= CFG_WAIT;  // master busy from next cycle
          end
        end
        CFG_WAIT: begin
          if (!busy) begin
            state <= CFG_ISSUE;
            if (nack) begin
              byte_idx <= '0;  // master already sent stop, redo entry
            end else if (byte_idx != 2'd2) begin
              byte_idx <= byte_idx + 2'd1;
            end else if (entry == cfg_idx_t'(CFG_LEN - 1)) begin
              state     <= CFG_DONE;
              init_over <= 1'b1;  // whole table acked
            end else begin
              entry    <= entry + cfg_idx_t'(1);
              byte_idx <= '0;
            end
          end
        end
        default: begin
          state <= CFG_DONE;  // stays until rst
        end
      endcase
    end
  end

  // done flag is sticky
  a_init_sticky : assert property (@(posedge cfg_clk)
    $fell(init_over) |-> $past(rst))
    else $error("init_over fell without rst");

endmodule

// File: hdmi_top.sv
`timescale 1ns/1ns

module hdmi_top import video_pkg::*; (
  input  logic   cfg_clk,
  input  logic   rst,
  input  logic   locked,
  input  rgb_t   pixel_data,
  output logic   rstn_out,
  output logic   iic_scl,
  output logic   sda_out_en,
  input  logic   sda_in,
  output logic   init_over,
  output coord_t act_x,
  output coord_t act_y,
  output logic   vs_out,
  output logic   hs_out,
  output logic   de_out,
  output rgb_t   pix_out
);

  sync_t      vt_sync;    // timing generator to pixel stage
  sync_t      px_sync;    // aligned with pix_out
  logic       i2c_start;
  logic       i2c_first;
  logic       i2c_last;
  logic [7:0] i2c_byte;
  logic       i2c_busy;
  logic       i2c_nack;

  reset_delay u_reset_delay (
    .cfg_clk (cfg_clk),
    .rst     (rst),
    .locked  (locked),
    .run     (rstn_out)  // release also gates video and config
  );

  video_timing u_video_timing (
    .cfg_clk (cfg_clk),
    .rst     (rst),
    .run     (rstn_out),
    .sync    (vt_sync),
    .act_x   (act_x),
    .act_y   (act_y)
  );

  pixel_stage u_pixel_stage (
    .cfg_clk    (cfg_clk),
    .rst        (rst),
    .run        (rstn_out),
    .sync_in    (vt_sync),
    .pixel_data (pixel_data),
    .sync_out   (px_sync),
    .pix_out    (pix_out)
  );

  tx_config u_tx_config (
    .cfg_clk   (cfg_clk),
    .rst       (rst),
    .run       (rstn_out),
    .start     (i2c_start),
    .first     (i2c_first),
    .last      (i2c_last),
    .tx_byte   (i2c_byte),
    .busy      (i2c_busy),
    .nack      (i2c_nack),
    .init_over (init_over)
  );

  i2c_master u_i2c_master (
    .cfg_clk    (cfg_clk),
    .rst        (rst),
    .start      (i2c_start),
    .first      (i2c_first),
    .last       (i2c_last),
    .tx_byte    (i2c_byte),
    .busy       (i2c_busy),
    .nack       (i2c_nack),
    .scl        (iic_scl),
    .sda_out_en (sda_out_en),  // board supplies open drain
    .sda_in     (sda_in)
  );

  assign vs_out = px_sync.vs;
  assign hs_out = px_sync.hs;
  assign de_out = px_sync.de;

endmodule

// File: tb_hdmi_top.sv
`timescale 1ns/1ns

module tb_hdmi_top import video_pkg::*; ();

  localparam int h_start      = H_SYNC + H_BP;          // first visible column
  localparam int v_start      = V_SYNC + V_BP;          // first visible line
  localparam int video_cycles = (v_start + 4) * H_TOTAL;  // up to four lines of video
  localparam int cycle_limit  = 2 * RST_DELAY_CYCLES
                                + (CFG_LEN + 1) * 3 * 9 * 4 * I2C_QUARTER
                                + video_cycles + 5000;  // lock steps and slack on top

  typedef struct packed {
    logic        locked;  // level for this step
    logic [15:0] hold;    // hold cycles or 0 to wait for release
  } lock_row_t;

  typedef struct packed {
    logic [15:0] write;  // expected {reg, data} on the bus
    logic        nack;   // refuse the reg byte once
  } cfg_row_t;

  localparam lock_row_t lock_steps [0:3] = '{
    '{1'b0, 16'd20},
    '{1'b1, 16'd4000},  // lock lost mid count
    '{1'b0, 16'd3},
    '{1'b1, 16'd0}      // full wait to release
  };

  localparam cfg_row_t cfg_rows [0:CFG_LEN-1] = '{
    '{16'h0801, 1'b0},
    '{16'h0A10, 1'b0},
    '{16'h1A00, 1'b0},
    '{16'h1E00, 1'b1},  // retried after one nack
    '{16'h2600, 1'b0},
    '{16'h3F01, 1'b0},
    '{16'hC701, 1'b0},
    '{16'h1A01, 1'b0}
  };

  logic        cfg_clk = 1'b0;
  logic        rst = 1'b1;
  logic        locked = 1'b0;
  rgb_t        pixel_data = '0;
  logic        sda_in = 1'b1;
  logic        rstn_out;
  logic        iic_scl;
  logic        sda_out_en;
  logic        init_over;
  coord_t      act_x;
  coord_t      act_y;
  logic        vs_out;
  logic        hs_out;
  logic        de_out;
  rgb_t        pix_out;
  int          cycle_cnt = 0;
  int          vid_n = 0;         // negedges since release
  logic        video_done = 1'b0;
  rgb_t        prev_pix = '0;     // pixel_data one cycle back
  logic [26:0] sync_exp;
  logic [26:0] coord_exp;
  logic        scl_d = 1'b1;
  logic        sda_d = 1'b1;      // master side of sda with 1 as released
  logic        ack_pull = 1'b0;   // slave holding sda low
  logic [7:0]  shift_in = '0;
  int          bit_n = 0;         // scl rises in this byte
  int          byte_n = 0;        // bytes acked in this transaction
  int          entry_n = 0;       // table rows completed
  logic        nack_now = 1'b0;
  logic        nack_done = 1'b0;
  int          wait_cnt;

  hdmi_top u_hdmi_top (.*);

  always #50 cfg_clk = ~cfg_clk;  // 100 ns period

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // {vs, hs, de, act_y, act_x} for raster count pos
  function automatic logic [26:0] raster_model(input int pos);
    int   h;
    int   v;
    logic de;
    if (pos < 0) return '0;  // still held clear
    h  = pos % H_TOTAL;
    v  = (pos / H_TOTAL) % V_TOTAL;
    de = (h >= h_start) && (h < h_start + H_ACT) && (v >= v_start) && (v < v_start + V_ACT);
    if (!de) return {v < V_SYNC, h < H_SYNC, 25'd0};  // coords idle in blanking
    return {v < V_SYNC, h < H_SYNC, 1'b1, 12'(v - v_start), 12'(h - h_start)};
  endfunction

  task automatic take_byte();
    if (entry_n >= CFG_LEN) abort_run("i2c byte written after the table was finished");
    if (byte_n > 2) abort_run("more than three bytes in one i2c transaction");
    if (byte_n == 0) begin
      check_val("i2c dev byte", shift_in, 8'h56);  // 0x2b plus write bit
    end else if (byte_n == 1) begin
      check_val("i2c reg byte", shift_in, cfg_rows[entry_n].write[15:8]);
    end else begin
      check_val("i2c data byte", shift_in, cfg_rows[entry_n].write[7:0]);
    end
    if (byte_n == 1 && cfg_rows[entry_n].nack && !nack_done) begin
      nack_now  = 1'b1;  // refuse this one
      nack_done = 1'b1;
    end
  endtask

  task automatic end_transaction();
    if (nack_now) begin
      check_val("i2c bytes before abort", byte_n, 2);  // same row comes again
    end else begin
      check_val("i2c bytes per write", byte_n, 3);
      entry_n++;
    end
    nack_now = 1'b0;
  endtask

  // pixel source, one new colour per clock
  initial begin
    void'($urandom(53652));
    forever begin
      @(posedge cfg_clk);
      pixel_data <= 24'($urandom);
    end
  end

  always @(posedge cfg_clk) begin
    sda_in <= sda_d && !ack_pull;  // wired and of both sides
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) abort_run("simulation timed out before the checks completed");
  end

  // i2c slave model sampled mid cycle
  always @(negedge cfg_clk) begin
    if (!rst) begin
      if (iic_scl && scl_d && sda_d && sda_out_en) begin
        bit_n  = 0;  // start
        byte_n = 0;
      end else if (iic_scl && scl_d && !sda_d && !sda_out_en) begin
        end_transaction();  // stop
      end else if (iic_scl && !scl_d) begin
        if (bit_n < 8) shift_in = {shift_in[6:0], !sda_out_en};  // msb first
        bit_n++;
        if (bit_n == 8) take_byte();
      end else if (!iic_scl && scl_d) begin
        if (bit_n == 8) begin
          ack_pull = !nack_now;  // ack bit starts
        end else if (bit_n == 9) begin
          ack_pull = 1'b0;
          bit_n    = 0;
          byte_n++;
        end
      end
      if (entry_n < CFG_LEN) check_val("init_over", init_over, 0);
    end
    scl_d = iic_scl;
    sda_d = !sda_out_en;
  end

  // raster and pixel checker against the counter model
  always @(negedge cfg_clk) begin
    if (!rst && !video_done) begin
      sync_exp  = raster_model(vid_n - 2);  // timing reg plus pixel reg
      coord_exp = raster_model(vid_n - 1);  // coords leave one stage earlier
      check_val("vs_out", vs_out, sync_exp[26]);
      check_val("hs_out", hs_out, sync_exp[25]);
      check_val("de_out", de_out, sync_exp[24]);
      check_val("act_y", act_y, coord_exp[23:12]);
      check_val("act_x", act_x, coord_exp[11:0]);
      check_val("pix_out", pix_out, sync_exp[24] ? prev_pix : 24'h0);
      if (rstn_out) vid_n++;
      if (vid_n - 2 >= video_cycles) video_done = 1'b1;
    end
    prev_pix = pixel_data;
  end

  initial begin
    repeat (16) @(posedge cfg_clk);
    rst <= 1'b0;
    @(negedge cfg_clk);
    check_val("rstn_out", rstn_out, 0);
    check_val("sda_out_en", sda_out_en, 0);
    check_val("iic_scl", iic_scl, 1);
    foreach (lock_steps[i]) begin
      @(posedge cfg_clk);
      locked <= lock_steps[i].locked;
      if (lock_steps[i].hold != 0) begin
        repeat (lock_steps[i].hold) begin
          @(negedge cfg_clk);
          check_val("rstn_out", rstn_out, 0);  // no early release
        end
      end else begin
        wait_cnt = 0;
        @(negedge cfg_clk);
        while (!rstn_out) begin
          wait_cnt++;
          @(negedge cfg_clk);
        end
        check_val("release delay", wait_cnt, RST_DELAY_CYCLES);
      end
    end
    while (!(video_done && init_over && entry_n == CFG_LEN)) @(negedge cfg_clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: project.f
video_pkg.sv
reset_delay.sv
video_timing.sv
pixel_stage.sv
i2c_master.sv
tx_config.sv
hdmi_top.sv
tb_hdmi_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_hdmi_top -o tb_hdmi_top
out=$(./obj_dir/tb_hdmi_top || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'NO ERRORS'
